/* verilog/softmax_config.svh */
// size constants of the softmax datapath, include wherever lane or word widths are needed
`ifndef SOFTMAX_CONFIG_SVH
`define SOFTMAX_CONFIG_SVH

// logits per packet
`define SM_LANES 16

// one q3.4 logit or one output byte
`define SM_LANE_W 8

// upstream fifo word
`define SM_WORD_W 16

// fifo words making up one packet
`define SM_WORDS 8

// full packet, lanes times lane width
`define SM_VEC_W 128

`endif

/* verilog/softmax_pkg.sv */
// fixed-point scalar types and packet structs shared by all softmax rtl, import with ::*
`default_nettype none

`include "softmax_config.svh"

package softmax_pkg;

  // q3.4 input logit
  typedef logic signed [`SM_LANE_W-1:0] lane_t;

  // clamped output byte
  typedef logic [`SM_LANE_W-1:0] prob_t;

  typedef logic [19:0] exp_t;         // uq12.8 exponential
  typedef logic [23:0] sum_t;         // uq16.8, exact sum of 16 exps
  typedef logic signed [8:0] log_t;   // sq5.4 natural log

  // lane i sits at bits 8i upward
  typedef logic [`SM_LANES-1:0][`SM_LANE_W-1:0] vec_t;

  typedef struct packed {
    vec_t data;
    logic use_softmax;  // mode sampled at packet completion
  } packet_t;

endpackage

`default_nettype wire

/* verilog/exp_unit.sv */
// approximate e^(y - ln_off) for one lane, one instance per lane inside the softmax core
`default_nettype none

module exp_unit
  import softmax_pkg::*;
(
  input  lane_t y,
  input  log_t  ln_off,
  output exp_t  exp_y
);

  localparam int unsigned       MANT_BASE  = 246;    // fitted 2^0 in q0.8
  localparam int unsigned       MANT_SLOPE = 11;     // ~ln2 * 256 / 16 per fraction step
  localparam logic signed [6:0] MAX_LSHIFT = 7'sd15; // mantissa << 13 overflows anyway

  logic signed [9:0]  diff;
  logic signed [10:0] a;
  logic signed [10:0] scaled;  // a * log2(e), still q.4
  logic signed [6:0]  u;
  logic [3:0]         v;
  logic [8:0]         mant;
  logic [6:0]         rsh;
  logic [23:0]        wide;

  assign diff = y - ln_off;  // both sign-extended to 10 bits
  assign a    = diff;

  // 1 + 1/2 - 1/16 = 1.4375
  assign scaled = a + (a >>> 1) - (a >>> 4);

  assign u    = scaled[10:4];
  assign v    = scaled[3:0];
  assign mant = 9'(MANT_BASE + MANT_SLOPE * v);  // linear fit of 2^v
  assign rsh  = 7'(-u);

  always_comb begin
    wide = '0;
    if (u < 0) begin
      wide = 24'(mant) >> rsh;   // large right shifts flush to zero
    end else if (u <= MAX_LSHIFT) begin
      wide = 24'(mant) << u[3:0];
    end else begin
      wide = '1;
    end
    // saturate at 2^20
    exp_y = (|wide[23:20]) ? '1 : wide[19:0];
  end

endmodule

`default_nettype wire

/* verilog/sum_tree.sv */
// exact combinational sum of the 16 lane exponentials, feeds the log unit in the core
`default_nettype none

`include "softmax_config.svh"

module sum_tree
  import softmax_pkg::*;
(
  input  exp_t exps [`SM_LANES],
  output sum_t sum
);

  localparam int N1 = `SM_LANES / 2;
  localparam int N2 = N1 / 2;
  localparam int N3 = N2 / 2;

  // one bit of growth per level keeps every level exact
  logic [20:0] lvl1 [N1];
  logic [21:0] lvl2 [N2];
  logic [22:0] lvl3 [N3];

  always_comb begin
    for (int i = 0; i < N1; i++) begin
      lvl1[i] = exps[2*i] + exps[2*i+1];
    end
    for (int i = 0; i < N2; i++) begin
      lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
    end
    for (int i = 0; i < N3; i++) begin
      lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
    end
  end

  assign sum = lvl3[0] + lvl3[1];  // 24 bits, uq16.8

endmodule

`default_nettype wire

/* verilog/log_unit.sv */
// leading-one approximation of ln(f) for the uq16.8 exponential sum, used by the core
`default_nettype none

module log_unit
  import softmax_pkg::*;
(
  input  sum_t f,
  output log_t ln_f
);

  localparam int LN_MAX = 255;
  localparam int LN_MIN = -256;

  logic [4:0]         p;        // leading-one position from bit 23, 24 when f is zero
  logic signed [4:0]  w;        // integer part of log2
  logic [23:0]        norm;
  logic [22:0]        frac;
  logic signed [27:0] a;        // q5.23 log2(f)
  logic signed [30:0] scaled;
  logic signed [30:0] shifted;

  always_comb begin
    p = 5'd24;
    // last hit wins, so the highest set bit decides
    for (int i = 0; i < 24; i++) begin
      if (f[i]) begin
        p = 5'(23 - i);
      end
    end
  end

  // bit 23 weighs 2^15 in uq16.8
  assign w    = 5'd15 - p;
  assign norm = f << p;
  assign frac = norm[22:0];     // bits below the leading one
  assign a    = {w, frac};

  // 1/2 + 1/8 + 1/16 = 11/16, close to ln2
  assign scaled  = (a >>> 1) + (a >>> 3) + (a >>> 4);
  assign shifted = scaled >>> 19;  // drop to 4 fraction bits

  always_comb begin
    if (shifted > LN_MAX) begin
      ln_f = log_t'(LN_MAX);
    end else if (shifted < LN_MIN) begin
      ln_f = log_t'(LN_MIN);
    end else begin
      ln_f = shifted[8:0];
    end
  end

endmodule

`default_nettype wire

/* verilog/softmax_core.sv */
// two-phase softmax over one latched packet, started by the top and answered with done_core
`default_nettype none

`include "softmax_config.svh"

module softmax_core
  import softmax_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  vec_t vec,
  output vec_t result,
  output logic done_core
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PHASE0,  // sum of exps and its log
    ST_PHASE1   // exp against the log offset
  } core_state_t;

  core_state_t state;

  lane_t lanes_q [`SM_LANES];
  exp_t  exps    [`SM_LANES];
  sum_t  sum;
  log_t  ln_sum;
  log_t  ln_q;
  log_t  ln_sel;
  vec_t  probs;

  function automatic prob_t clamp_byte(input exp_t e);
    // anything at or above 1.0 saturates the byte
    return (|e[$bits(exp_t)-1:`SM_LANE_W]) ? '1 : prob_t'(e[`SM_LANE_W-1:0]);
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      done_core <= 1'b0;
    end else begin
      done_core <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_PHASE0;
          end
        end
        ST_PHASE0: state <= ST_PHASE1;
        ST_PHASE1: begin
          state     <= ST_IDLE;
          done_core <= 1'b1;  // same edge as result
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      for (int i = 0; i < `SM_LANES; i++) begin
        lanes_q[i] <= lane_t'(vec[i]);
      end
    end
    if (state == ST_PHASE0) begin
      ln_q <= ln_sum;
    end
    if (state == ST_PHASE1) begin
      result <= probs;  // held until the next run
    end
  end

  // phase 0 runs the exps unshifted
  assign ln_sel = (state == ST_PHASE1) ? ln_q : '0;

  for (genvar gi = 0; gi < `SM_LANES; gi++) begin : g_lane
    exp_unit exp_i (
      .y      (lanes_q[gi]),
      .ln_off (ln_sel),
      .exp_y  (exps[gi])
    );
    assign probs[gi] = clamp_byte(exps[gi]);
  end

  sum_tree tree_i (
    .exps (exps),
    .sum  (sum)
  );

  log_unit log_i (
    .f    (sum),
    .ln_f (ln_sum)
  );

endmodule

`default_nettype wire

/* verilog/word_gather.sv */
// reads the show-ahead fifo and packs eight 16-bit words into one packet for the top
`default_nettype none

`include "softmax_config.svh"

module word_gather
  import softmax_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  empty,
  input  logic [`SM_WORD_W-1:0] data_in,
  input  logic                  softmax_en,
  input  logic                  pkt_release,
  output logic                  rd_en,
  output packet_t               pkt,
  output logic                  pkt_ready
);

  localparam int CNT_W = $clog2(`SM_WORDS + 1);

  logic [CNT_W-1:0]     count;
  logic [`SM_VEC_W-1:0] shift_q;  // first word ends up in lanes 0-1
  logic                 mode_q;
  logic                 take;
  logic                 last_take;

  assign pkt_ready = (count == CNT_W'(`SM_WORDS));

  // rd_en high means the previous word is still being popped
  assign take      = !empty && !rd_en && !pkt_ready;
  assign last_take = take && (count == CNT_W'(`SM_WORDS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count  <= '0;
      rd_en  <= 1'b0;
      mode_q <= 1'b0;
    end else begin
      rd_en <= take;  // pop follows the take by one cycle
      if (pkt_release) begin
        count <= '0;
      end else if (take) begin
        count <= count + 1'b1;
      end
      if (last_take) begin
        mode_q <= softmax_en;  // mode fixed per packet
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      shift_q <= {data_in, shift_q[`SM_VEC_W-1:`SM_WORD_W]};
    end
  end

  assign pkt.data        = shift_q;
  assign pkt.use_softmax = mode_q;

endmodule

`default_nettype wire

/* verilog/softmax_top.sv */
// softmax accelerator top, fifo in, valid/done out, routes each packet to core or bypass
`default_nettype none

`include "softmax_config.svh"

module softmax_top
  import softmax_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  softmax_en,
  input  logic                  empty,
  input  logic [`SM_WORD_W-1:0] data_in,
  output logic                  rd_en,
  output logic                  valid,
  input  logic                  done,
  output vec_t                  data_out
);

  typedef enum logic [1:0] {
    ST_WAIT_PKT,
    ST_START_CORE,
    ST_WAIT_CORE,
    ST_HOLD_OUT    // result pending downstream
  } top_state_t;

  top_state_t state;

  packet_t pkt;
  logic    pkt_ready;
  logic    pkt_release;
  logic    start;
  vec_t    result;
  logic    done_core;

  assign start       = (state == ST_START_CORE);
  assign pkt_release = (state == ST_HOLD_OUT) && done;  // frees the gather for the next packet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_WAIT_PKT;
      valid    <= 1'b0;
      data_out <= '0;
    end else begin
      valid <= 1'b0;
      case (state)
        ST_WAIT_PKT: begin
          if (pkt_ready) begin
            if (pkt.use_softmax) begin
              state <= ST_START_CORE;
            end else begin
              // bypass, packet goes out unchanged
              data_out <= pkt.data;
              valid    <= 1'b1;
              state    <= ST_HOLD_OUT;
            end
          end
        end
        ST_START_CORE: state <= ST_WAIT_CORE;
        ST_WAIT_CORE: begin
          if (done_core) begin
            data_out <= result;
            valid    <= 1'b1;
            state    <= ST_HOLD_OUT;
          end
        end
        ST_HOLD_OUT: begin
          if (done) begin
            state <= ST_WAIT_PKT;
          end
        end
        default: state <= ST_WAIT_PKT;
      endcase
    end
  end

  word_gather gather_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .empty       (empty),
    .data_in     (data_in),
    .softmax_en  (softmax_en),
    .pkt_release (pkt_release),
    .rd_en       (rd_en),
    .pkt         (pkt),
    .pkt_ready   (pkt_ready)
  );

  softmax_core core_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .vec       (pkt.data),  // gather holds it until release
    .result    (result),
    .done_core (done_core)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// clock and active-low reset source for the softmax testbench, instantiate once in the tb top
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;  // released off the edge
  end

endmodule

`default_nettype wire

/* bench/softmax_tb.sv */
// directed testbench for softmax_top with a show-ahead fifo model and an integer reference model
`default_nettype none

`include "softmax_config.svh"

module softmax_tb
  import softmax_pkg::*;
();

  localparam int          TIMEOUT = 200;
  localparam int unsigned SEED    = 32'h8a23_7330;

  logic                  clk, rst_n, softmax_en, empty, rd_en, valid, done;
  logic [`SM_WORD_W-1:0] data_in;
  vec_t                  data_out;

  logic [`SM_WORD_W-1:0] fifo_q [$];  // words waiting upstream
  int unsigned stim_state = SEED;
  int unsigned gap_state  = SEED;     // separate stream for empty gaps
  int          max_gap     = 0;
  int          gap_left    = 0;
  int          pop_count   = 0;
  int          valid_count = 0;
  int          errors      = 0;
  int          timeouts    = 0;
  logic        prev_rd     = 1'b0;

  tb_clock_gen #(.PERIOD(4), .RST_CYCLES(8)) clock_gen_i (.clk(clk), .rst_n(rst_n));

  softmax_top softmax_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .softmax_en (softmax_en),
    .empty      (empty),
    .data_in    (data_in),
    .rd_en      (rd_en),
    .valid      (valid),
    .done       (done),
    .data_out   (data_out)
  );

  function automatic int unsigned lcg_next(inout int unsigned state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  function automatic vec_t random_vec(input bit narrow);
    vec_t        v;
    int unsigned r;
    for (int i = 0; i < `SM_LANES; i++) begin
      r    = lcg_next(stim_state);
      v[i] = narrow ? 8'((r >> 16) % 48) - 8'd24 : r[23:16];  // narrow keeps lanes within +-1.5
    end
    return v;
  endfunction

  // e^(y - off): scale by 1.4375, split int/frac, linear 2^frac, shift, saturate at 2^20
  function automatic int model_exp(input int y, input int off);
    int     a, scaled, u, v, mant;
    longint val;
    a      = y - off;
    scaled = a + (a >>> 1) - (a >>> 4);
    u      = scaled >>> 4;
    v      = scaled & 15;
    mant   = 246 + 11 * v;
    if (u < 0) begin
      val = (-u > 30) ? 0 : (mant >> -u);
    end else begin
      val = (u > 20) ? (64'd1 << 21) : (longint'(mant) << u);
    end
    return (val >= (64'd1 << 20)) ? (1 << 20) - 1 : int'(val);
  endfunction

  // leading-one log2 in q5.23, scaled by 11/16, back to q.4 and clamped
  function automatic int model_log(input longint f);
    int     p, w;
    longint frac, a, scaled, sh;
    p = 24;
    for (int i = 23; i >= 0; i--) begin
      if (p == 24 && ((f >> i) & 1)) p = 23 - i;
    end
    w      = 15 - p;
    frac   = (f << p) & 64'h7f_ffff;
    a      = longint'(w) * 64'sd8388608 + frac;
    scaled = (a >>> 1) + (a >>> 3) + (a >>> 4);
    sh     = scaled >>> 19;
    if (sh > 255) sh = 255;
    if (sh < -256) sh = -256;
    return int'(sh);
  endfunction

  function automatic vec_t model_softmax(input vec_t v);
    longint sum;
    int     ln, e;
    vec_t   r;
    sum = 0;
    for (int i = 0; i < `SM_LANES; i++) sum += model_exp(int'($signed(v[i])), 0);
    ln = model_log(sum);
    for (int i = 0; i < `SM_LANES; i++) begin
      e    = model_exp(int'($signed(v[i])), ln);
      r[i] = (e > 255) ? 8'hff : 8'(e);  // clamp to one byte
    end
    return r;
  endfunction

  task automatic check_vec(input string name, input vec_t exp_v, input vec_t act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_b, input logic act_b);
    if (act_b !== exp_b) begin
      errors++;
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp_b, act_b);
    end
  endtask

  task automatic check_count(input string name, input int exp_n, input int act_n);
    if (act_n != exp_n) begin
      errors++;
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp_n, act_n);
    end
  endtask

  // show-ahead fifo, pops on rd_en, plus protocol monitor
  always @(posedge clk) begin
    #1;
    if (valid === 1'b1) valid_count++;
    if (rd_en === 1'b1) begin
      if (prev_rd) begin
        errors++;
        $display("rd_en was high on two consecutive cycles at %0t", $time);
      end
      if (fifo_q.size() == 0) begin
        errors++;
        $display("rd_en popped an empty fifo at %0t", $time);
      end else begin
        void'(fifo_q.pop_front());
        pop_count++;
        gap_left = (max_gap > 0) ? int'(lcg_next(gap_state) % (max_gap + 1)) : 0;
      end
    end
    prev_rd = (rd_en === 1'b1);
    if (gap_left > 0) begin
      empty = 1'b1;
      gap_left--;
    end else if (fifo_q.size() == 0) begin
      empty = 1'b1;
    end else begin
      empty   = 1'b0;
      data_in = fifo_q[0];
    end
  end

  task automatic push_packet(input vec_t v);
    @(negedge clk);
    for (int k = 0; k < `SM_WORDS; k++) fifo_q.push_back(v[2*k+1 -: 2]);  // lanes 0-1 first
  endtask

  task automatic wait_valid(input string what);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(posedge clk);
      #1;
      if (valid) break;
    end
    if (n == TIMEOUT) begin
      timeouts++;
      $display("timeout, no valid strobe for %s within %0d cycles", what, TIMEOUT);
    end
  endtask

  task automatic hold_and_check(input int cycles, input vec_t held);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      check_vec("data_out", held, data_out);
      check_bit("rd_en", 1'b0, rd_en);
      check_bit("valid", 1'b0, valid);
    end
  endtask

  task automatic send_done();
    @(negedge clk);
    pop_count   = 0;
    valid_count = 0;
    @(posedge clk);
    #1;
    done = 1'b1;
    @(posedge clk);
    #1;
    done = 1'b0;
  endtask

  task automatic finish_packet(input vec_t expv);
    hold_and_check(3, expv);
    @(negedge clk);
    check_count("pops", `SM_WORDS, pop_count);
    check_count("valid strobes", 1, valid_count);
    send_done();
  endtask

  task automatic run_packet(input vec_t v, input logic en);
    vec_t expv;
    expv = en ? model_softmax(v) : v;
    @(posedge clk);
    #1;
    softmax_en = en;
    push_packet(v);
    wait_valid(en ? "softmax packet" : "bypass packet");
    check_vec("data_out", expv, data_out);
    finish_packet(expv);
  endtask

  task automatic test_reset();
    int n;
    for (n = 0; n < TIMEOUT && rst_n !== 1'b1; n++) @(posedge clk);
    if (n == TIMEOUT) begin
      timeouts++;
      $display("timeout, reset never released");
    end
    @(posedge clk);
    #1;
    check_bit("valid", 1'b0, valid);
    check_bit("rd_en", 1'b0, rd_en);
    check_vec("data_out", '0, data_out);
  endtask

  task automatic test_bypass();
    vec_t v;
    for (int i = 0; i < `SM_LANES; i++) v[i] = 8'(17 * i + 1);  // distinct per lane
    run_packet(v, 1'b0);
    run_packet(random_vec(1'b0), 1'b0);
  endtask

  task automatic test_equal_logits();
    logic [7:0] vals [3];
    vals = '{8'h00, 8'h10, 8'he0};
    foreach (vals[k]) run_packet({`SM_LANES{vals[k]}}, 1'b1);
  endtask

  task automatic test_random_packets();
    vec_t v;
    v    = {`SM_LANES{8'h80}};
    v[0] = 8'h7f;  // one dominant lane, rest round to zero
    run_packet(v, 1'b1);
    for (int k = 0; k < 6; k++) run_packet(random_vec(k[0]), 1'b1);
  endtask

  task automatic test_fifo_protocol();
    @(negedge clk);
    max_gap = 3;
    for (int k = 0; k < 4; k++) run_packet(random_vec(1'b0), k[0]);
    @(negedge clk);
    max_gap = 0;
  endtask

  task automatic test_backpressure();
    vec_t a, b, exp_a;
    a     = random_vec(1'b1);
    b     = random_vec(1'b1);
    exp_a = model_softmax(a);
    @(posedge clk);
    #1;
    softmax_en = 1'b1;
    push_packet(a);
    wait_valid("first held packet");
    check_vec("data_out", exp_a, data_out);
    push_packet(b);  // words ready but must not be read yet
    hold_and_check(20, exp_a);
    @(negedge clk);
    check_count("pops", `SM_WORDS, pop_count);
    check_count("valid strobes", 1, valid_count);
    send_done();
    wait_valid("packet after release");
    check_vec("data_out", model_softmax(b), data_out);
    finish_packet(model_softmax(b));
  endtask

  initial begin
    softmax_en = 1'b0;
    done       = 1'b0;
    empty      = 1'b1;
    data_in    = '0;
    test_reset();
    test_bypass();
    test_equal_logits();
    test_random_packets();
    test_fifo_protocol();
    test_backpressure();
    repeat (4) @(posedge clk);
    $display("closing summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/softmax_pkg.sv
verilog/exp_unit.sv
verilog/sum_tree.sv
verilog/log_unit.sv
verilog/softmax_core.sv
verilog/word_gather.sv
verilog/softmax_top.sv
bench/tb_clock_gen.sv
bench/softmax_tb.sv
